// ==== bench/tb_axil_mem_system.sv ====
/* Testbench for the AXI-Lite memory subsystem with mem_words at 4096.
   Memory contents are not reset, so only words written during the run are read back */
`timescale 1ns/1ns
module tb_axil_mem_system;
    import axil_pkg::*;

    localparam int mem_words     = 4096;
    localparam int full_words    = 200;
    localparam int strobe_cases  = 64;
    localparam int subword_words = 32;
    localparam int bp_cases      = 8;
    localparam int max_hold      = 12;
    // About five cycles per transaction, plus the held response cycles
    localparam int txn_total = 2 * full_words + 3 * strobe_cases + 5 * subword_words
                               + 24 + 4 * bp_cases;
    localparam int timeout_cycles = 4 * (5 * txn_total + 2 * bp_cases * max_hold);
    localparam addr_t bad_addr [3] = '{32'h2000_0000, regs_base + regs_span,
                                       mem_base + mem_span};

    logic       aclk;
    logic       aresetn;
    addr_t      s_axil_awaddr;
    logic [2:0] s_axil_awprot;
    logic       s_axil_awvalid;
    logic       s_axil_awready;
    data_t      s_axil_wdata;
    strb_t      s_axil_wstrb;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    resp_t      s_axil_bresp;
    logic       s_axil_bvalid;
    logic       s_axil_bready;
    addr_t      s_axil_araddr;
    logic [2:0] s_axil_arprot;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    data_t      s_axil_rdata;
    resp_t      s_axil_rresp;
    logic       s_axil_rvalid;
    logic       s_axil_rready;
    logic [7:0] led;

    data_t shadow [mem_words];  // Expected memory contents
    int    cycle_count = 0;

    axil_mem_system #(
        .mem_words (mem_words)
    ) UUT (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Test failures found");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // Each byte lane takes the new byte only where its strobe is set
    function automatic data_t merge_strobes(input data_t old_word, input data_t new_word,
                                            input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) merged[8*i +: 8] = new_word[8*i +: 8];
        end
        return merged;
    endfunction

    // Byte offset picks a word, a half word or a byte, moved down to bit 0
    function automatic data_t expected_read(input data_t word, input logic [1:0] offset);
        data_t mask;
        case (offset)
            2'd0:    mask = 32'hffff_ffff;
            2'd2:    mask = 32'h0000_ffff;
            default: mask = 32'h0000_00ff;
        endcase
        return (word >> (8 * offset)) & mask;
    endfunction

    // With hold set, bready stays low that many cycles while the same write is offered again
    task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                              input int hold, output resp_t resp);
        int passes;
        passes = (hold > 0) ? 2 : 1;
        @(posedge aclk);
        s_axil_awaddr  <= addr;
        s_axil_wdata   <= data;
        s_axil_wstrb   <= strb;
        s_axil_awvalid <= 1'b1;
        s_axil_wvalid  <= 1'b1;
        for (int p = 0; p < passes; p++) begin
            @(negedge aclk);
            while (!s_axil_awready) @(negedge aclk);
            check_value("wready", s_axil_wready, 1'b1);
            @(posedge aclk);    // Address and data accepted here
            if (p == passes - 1) begin
                s_axil_awvalid <= 1'b0;
                s_axil_wvalid  <= 1'b0;
            end
            for (int i = 0; i < hold && p == 0; i++) begin
                @(negedge aclk);
                check_value("bvalid", s_axil_bvalid, 1'b1);
                check_value("awready", s_axil_awready, 1'b0);
                check_value("wready", s_axil_wready, 1'b0);
                @(posedge aclk);
            end
            s_axil_bready <= 1'b1;
            @(negedge aclk);
            while (!s_axil_bvalid) @(negedge aclk);
            resp = s_axil_bresp;
            @(posedge aclk);
            s_axil_bready <= 1'b0;
        end
    endtask

    task automatic axil_read(input addr_t addr, input int hold, output data_t data,
                             output resp_t resp);
        int    passes;
        data_t held;
        passes = (hold > 0) ? 2 : 1;
        @(posedge aclk);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        for (int p = 0; p < passes; p++) begin
            @(negedge aclk);
            while (!s_axil_arready) @(negedge aclk);
            @(posedge aclk);
            if (p == passes - 1) s_axil_arvalid <= 1'b0;
            for (int i = 0; i < hold && p == 0; i++) begin
                @(negedge aclk);
                if (i == 0) held = s_axil_rdata;
                check_value("rvalid", s_axil_rvalid, 1'b1);
                check_value("arready", s_axil_arready, 1'b0);
                check_value("rdata_held", s_axil_rdata, held);
                @(posedge aclk);
            end
            s_axil_rready <= 1'b1;
            @(negedge aclk);
            while (!s_axil_rvalid) @(negedge aclk);
            data = s_axil_rdata;
            resp = s_axil_rresp;
            if (hold > 0 && p == 0) begin
                check_value("rdata_held", data, held);
            end
            @(posedge aclk);
            s_axil_rready <= 1'b0;
        end
    endtask

    initial begin
        int    idx_q[$];
        int    idx;
        int    hold;
        addr_t addr;
        data_t data;
        data_t rdata;
        data_t first;
        data_t scratch_val;
        strb_t strb;
        resp_t resp;

        void'($urandom(32'h2dfa));
        aresetn        = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awprot  = 3'b000;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arprot  = 3'b000;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;

        // Full words are all written first so that repeated indices overwrite each other
        for (int n = 0; n < full_words; n++) begin
            idx  = $urandom % mem_words;
            data = $urandom;
            axil_write(mem_base + 4 * idx, data, 4'hf, 0, resp);
            check_value("bresp", resp, resp_okay);
            shadow[idx] = data;
            idx_q.push_back(idx);
        end
        foreach (idx_q[n]) begin
            axil_read(mem_base + 4 * idx_q[n], 0, rdata, resp);
            check_value("rdata", rdata, shadow[idx_q[n]]);
            check_value("rresp", resp, resp_okay);
        end

        for (int n = 0; n < strobe_cases; n++) begin
            idx  = $urandom % mem_words;
            data = $urandom;
            axil_write(mem_base + 4 * idx, data, 4'hf, 0, resp);
            shadow[idx] = data;
            data = $urandom;
            strb = strb_t'($urandom);
            axil_write(mem_base + 4 * idx, data, strb, 0, resp);
            check_value("bresp", resp, resp_okay);
            shadow[idx] = merge_strobes(shadow[idx], data, strb);
            axil_read(mem_base + 4 * idx, 0, rdata, resp);
            check_value("rdata", rdata, shadow[idx]);
        end

        for (int n = 0; n < subword_words; n++) begin
            idx  = $urandom % mem_words;
            data = $urandom;
            axil_write(mem_base + 4 * idx, data, 4'hf, 0, resp);
            shadow[idx] = data;
            for (int off = 0; off < 4; off++) begin
                axil_read(mem_base + 4 * idx + off, 0, rdata, resp);
                check_value("rdata", rdata, expected_read(shadow[idx], off));
                check_value("rresp", resp, resp_okay);
            end
        end

        // Register block
        scratch_val = $urandom;
        axil_write(regs_base, scratch_val, 4'hf, 0, resp);
        check_value("bresp", resp, resp_okay);
        data = $urandom;
        strb = strb_t'($urandom);
        axil_write(regs_base, data, strb, 0, resp);
        scratch_val = merge_strobes(scratch_val, data, strb);
        axil_read(regs_base, 0, rdata, resp);
        check_value("rdata", rdata, scratch_val);
        data = $urandom;
        axil_write(regs_base + 4, data, 4'hf, 0, resp);
        @(negedge aclk);
        check_value("led", led, data[7:0]);
        axil_read(regs_base + 4, 0, rdata, resp);
        check_value("rdata", rdata, {24'd0, data[7:0]});
        axil_read(regs_base + 8, 0, first, resp);
        axil_read(regs_base + 8, 0, rdata, resp);
        check_value("counter_rising", rdata > first, 1'b1);
        axil_write(regs_base + 8, 32'h0, 4'hf, 0, resp);
        check_value("bresp", resp, resp_okay);
        axil_read(regs_base + 8, 0, data, resp);
        check_value("counter_rising", data > rdata, 1'b1);
        axil_write(regs_base + 12, $urandom, 4'hf, 0, resp);
        check_value("bresp", resp, resp_slverr);
        axil_read(regs_base + 12, 0, rdata, resp);
        check_value("rresp", resp, resp_slverr);
        check_value("rdata", rdata, 32'h0);

        // Unmapped addresses get DECERR and both windows must still answer after them
        for (int n = 0; n < 3; n++) begin
            axil_write(bad_addr[n], $urandom, 4'hf, 0, resp);
            check_value("bresp", resp, resp_decerr);
            axil_read(bad_addr[n], 0, rdata, resp);
            check_value("rresp", resp, resp_decerr);
            check_value("rdata", rdata, 32'h0);
        end
        idx  = $urandom % mem_words;
        data = $urandom;
        axil_write(mem_base + 4 * idx, data, 4'hf, 0, resp);
        check_value("bresp", resp, resp_okay);
        shadow[idx] = data;
        axil_read(mem_base + 4 * idx, 0, rdata, resp);
        check_value("rdata", rdata, shadow[idx]);
        axil_read(regs_base, 0, rdata, resp);
        check_value("rdata", rdata, scratch_val);

        for (int n = 0; n < bp_cases; n++) begin
            idx  = $urandom % mem_words;
            addr = mem_base + 4 * idx;
            data = $urandom;
            hold = 1 + $urandom % max_hold;
            axil_write(addr, data, 4'hf, hold, resp);
            check_value("bresp", resp, resp_okay);
            shadow[idx] = data;
            hold = 1 + $urandom % max_hold;
            axil_read(addr, hold, rdata, resp);
            check_value("rdata", rdata, shadow[idx]);
            check_value("rresp", resp, resp_okay);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/axil_pkg.sv
logic/axil_memory.sv
logic/axil_ctrl_regs.sv
logic/axil_splitter.sv
logic/axil_mem_system.sv
bench/tb_axil_mem_system.sv

// ==== logic/axil_ctrl_regs.sv ====
/* Control registers on AXI-Lite, decoded on address bits [3:2] only.
   Offset 0xC is reserved and answers SLVERR */
`timescale 1ns/1ns
module axil_ctrl_regs (
    input  logic            aclk,
    input  logic            aresetn,

    input  axil_pkg::addr_t s_axil_awaddr,
    input  logic [2:0]      s_axil_awprot,
    input  logic            s_axil_awvalid,
    output logic            s_axil_awready,

    input  axil_pkg::data_t s_axil_wdata,
    input  axil_pkg::strb_t s_axil_wstrb,
    input  logic            s_axil_wvalid,
    output logic            s_axil_wready,

    output axil_pkg::resp_t s_axil_bresp,
    output logic            s_axil_bvalid,
    input  logic            s_axil_bready,

    input  axil_pkg::addr_t s_axil_araddr,
    input  logic [2:0]      s_axil_arprot,
    input  logic            s_axil_arvalid,
    output logic            s_axil_arready,

    output axil_pkg::data_t s_axil_rdata,
    output axil_pkg::resp_t s_axil_rresp,
    output logic            s_axil_rvalid,
    input  logic            s_axil_rready,

    output logic [7:0]      led
);
    import axil_pkg::*;

    data_t      scratch;
    logic [7:0] led_reg;
    data_t      cycle_cnt;  // Free running, writes to it are dropped
    logic       live;
    logic       wr_fire;
    logic       rd_fire;

    assign wr_fire = live && !s_axil_bvalid && s_axil_awvalid && s_axil_wvalid;
    assign s_axil_awready = wr_fire;
    assign s_axil_wready  = wr_fire;
    assign s_axil_arready = live && !s_axil_rvalid;
    assign rd_fire = s_axil_arvalid && s_axil_arready;
    assign led     = led_reg;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            live      <= 1'b0;
            scratch   <= '0;
            led_reg   <= '0;
            cycle_cnt <= '0;
        end else begin
            live      <= 1'b1;
            cycle_cnt <= cycle_cnt + 1'b1;
            if (wr_fire && s_axil_awaddr[3:2] == 2'd0) begin
                for (int i = 0; i < 4; i++) begin
                    if (s_axil_wstrb[i]) begin
                        scratch[8*i +: 8] <= s_axil_wdata[8*i +: 8];
                    end
                end
            end
            if (wr_fire && s_axil_awaddr[3:2] == 2'd1 && s_axil_wstrb[0]) begin
                led_reg <= s_axil_wdata[7:0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
            if (rd_fire) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            s_axil_bresp <= (s_axil_awaddr[3:2] == 2'd3) ? resp_slverr : resp_okay;
        end
        if (rd_fire) begin
            s_axil_rresp <= (s_axil_araddr[3:2] == 2'd3) ? resp_slverr : resp_okay;
            case (s_axil_araddr[3:2])
                2'd0:    s_axil_rdata <= scratch;
                2'd1:    s_axil_rdata <= {24'd0, led_reg};
                2'd2:    s_axil_rdata <= cycle_cnt;
                default: s_axil_rdata <= '0;
            endcase
        end
    end

    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

endmodule

// ==== logic/axil_mem_system.sv ====
/* AXI-Lite memory subsystem with block RAM at mem_base and control registers at regs_base.
   mem_words may be at most mem_span / 4 */
`timescale 1ns/1ns
module axil_mem_system #(
    parameter int mem_words = 4096
) (
    input  logic            aclk,
    input  logic            aresetn,

    input  axil_pkg::addr_t s_axil_awaddr,
    input  logic [2:0]      s_axil_awprot,
    input  logic            s_axil_awvalid,
    output logic            s_axil_awready,
    input  axil_pkg::data_t s_axil_wdata,
    input  axil_pkg::strb_t s_axil_wstrb,
    input  logic            s_axil_wvalid,
    output logic            s_axil_wready,
    output axil_pkg::resp_t s_axil_bresp,
    output logic            s_axil_bvalid,
    input  logic            s_axil_bready,
    input  axil_pkg::addr_t s_axil_araddr,
    input  logic [2:0]      s_axil_arprot,
    input  logic            s_axil_arvalid,
    output logic            s_axil_arready,
    output axil_pkg::data_t s_axil_rdata,
    output axil_pkg::resp_t s_axil_rresp,
    output logic            s_axil_rvalid,
    input  logic            s_axil_rready,

    output logic [7:0]      led
);
    import axil_pkg::*;

    addr_t      m_mem_awaddr, m_mem_araddr, m_reg_awaddr, m_reg_araddr;
    data_t      m_mem_wdata, m_mem_rdata, m_reg_wdata, m_reg_rdata;
    strb_t      m_mem_wstrb, m_reg_wstrb;
    resp_t      m_mem_bresp, m_mem_rresp, m_reg_bresp, m_reg_rresp;
    logic [2:0] m_mem_awprot, m_mem_arprot, m_reg_awprot, m_reg_arprot;
    logic       m_mem_awvalid, m_mem_awready, m_mem_wvalid, m_mem_wready;
    logic       m_mem_bvalid, m_mem_bready, m_mem_arvalid, m_mem_arready;
    logic       m_mem_rvalid, m_mem_rready;
    logic       m_reg_awvalid, m_reg_awready, m_reg_wvalid, m_reg_wready;
    logic       m_reg_bvalid, m_reg_bready, m_reg_arvalid, m_reg_arready;
    logic       m_reg_rvalid, m_reg_rready;

    // Port names of the splitter match the top ports and the wires above
    axil_splitter u_splitter (.*);

    axil_memory #(
        .mem_words (mem_words)
    ) u_memory (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awaddr  (m_mem_awaddr),
        .s_axil_awprot  (m_mem_awprot),
        .s_axil_awvalid (m_mem_awvalid),
        .s_axil_awready (m_mem_awready),
        .s_axil_wdata   (m_mem_wdata),
        .s_axil_wstrb   (m_mem_wstrb),
        .s_axil_wvalid  (m_mem_wvalid),
        .s_axil_wready  (m_mem_wready),
        .s_axil_bresp   (m_mem_bresp),
        .s_axil_bvalid  (m_mem_bvalid),
        .s_axil_bready  (m_mem_bready),
        .s_axil_araddr  (m_mem_araddr),
        .s_axil_arprot  (m_mem_arprot),
        .s_axil_arvalid (m_mem_arvalid),
        .s_axil_arready (m_mem_arready),
        .s_axil_rdata   (m_mem_rdata),
        .s_axil_rresp   (m_mem_rresp),
        .s_axil_rvalid  (m_mem_rvalid),
        .s_axil_rready  (m_mem_rready)
    );

    axil_ctrl_regs u_regs (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awaddr  (m_reg_awaddr),
        .s_axil_awprot  (m_reg_awprot),
        .s_axil_awvalid (m_reg_awvalid),
        .s_axil_awready (m_reg_awready),
        .s_axil_wdata   (m_reg_wdata),
        .s_axil_wstrb   (m_reg_wstrb),
        .s_axil_wvalid  (m_reg_wvalid),
        .s_axil_wready  (m_reg_wready),
        .s_axil_bresp   (m_reg_bresp),
        .s_axil_bvalid  (m_reg_bvalid),
        .s_axil_bready  (m_reg_bready),
        .s_axil_araddr  (m_reg_araddr),
        .s_axil_arprot  (m_reg_arprot),
        .s_axil_arvalid (m_reg_arvalid),
        .s_axil_arready (m_reg_arready),
        .s_axil_rdata   (m_reg_rdata),
        .s_axil_rresp   (m_reg_rresp),
        .s_axil_rvalid  (m_reg_rvalid),
        .s_axil_rready  (m_reg_rready),
        .led            (led)
    );

endmodule

// ==== logic/axil_memory.sv ====
/* Block-RAM AXI-Lite slave, one transaction per direction, prot ignored.
   Word index wraps modulo mem_words, and reset leaves the contents as they are */
`timescale 1ns/1ns
module axil_memory #(
    parameter int mem_words = 4096
) (
    input  logic            aclk,
    input  logic            aresetn,

    input  axil_pkg::addr_t s_axil_awaddr,
    input  logic [2:0]      s_axil_awprot,
    input  logic            s_axil_awvalid,
    output logic            s_axil_awready,

    input  axil_pkg::data_t s_axil_wdata,
    input  axil_pkg::strb_t s_axil_wstrb,
    input  logic            s_axil_wvalid,
    output logic            s_axil_wready,

    output axil_pkg::resp_t s_axil_bresp,
    output logic            s_axil_bvalid,
    input  logic            s_axil_bready,

    input  axil_pkg::addr_t s_axil_araddr,
    input  logic [2:0]      s_axil_arprot,
    input  logic            s_axil_arvalid,
    output logic            s_axil_arready,

    output axil_pkg::data_t s_axil_rdata,
    output axil_pkg::resp_t s_axil_rresp,
    output logic            s_axil_rvalid,
    input  logic            s_axil_rready
);
    import axil_pkg::*;

    data_t       mem [mem_words];
    logic        live;      // Holds every ready low for the first cycle out of reset
    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] wr_idx;
    logic [31:0] rd_idx;

    // Shift the addressed byte down to lane 0 and keep the sub-word it starts
    function automatic data_t extract(input data_t word, input logic [1:0] offset);
        data_t shifted;
        shifted = word >> {offset, 3'b000};
        case (offset)
            2'd0:    extract = shifted;
            2'd2:    extract = shifted & 32'h0000_ffff;
            default: extract = shifted & 32'h0000_00ff;
        endcase
    endfunction

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    assign wr_idx  = (s_axil_awaddr >> 2) % mem_words;
    assign rd_idx  = (s_axil_araddr >> 2) % mem_words;

    // Address and data are taken together, and never while a response waits
    assign wr_fire = live && !s_axil_bvalid && s_axil_awvalid && s_axil_wvalid;
    assign s_axil_awready = wr_fire;
    assign s_axil_wready  = wr_fire;
    assign s_axil_bresp   = resp_okay;

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (s_axil_wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= s_axil_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axil_bvalid <= 1'b0;
        end else if (wr_fire) begin
            s_axil_bvalid <= 1'b1;
        end else if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
        end
    end

    assign s_axil_arready = live && !s_axil_rvalid;
    assign rd_fire        = s_axil_arvalid && s_axil_arready;
    assign s_axil_rresp   = resp_okay;

    always_ff @(posedge aclk) begin
        if (rd_fire) begin
            s_axil_rdata <= extract(mem[rd_idx], s_axil_araddr[1:0]);
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s_axil_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

    a_rdata_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_rvalid && !s_axil_rready |=> $stable(s_axil_rdata));

endmodule

// ==== logic/axil_pkg.sv ====
/* Bus types, response codes and address map of the AXI-Lite memory subsystem.
   The two windows must not overlap, and each span must be a multiple of 4 bytes */
package axil_pkg;

    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;    // One strobe per data byte
    typedef logic [1:0]  resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;
    localparam resp_t resp_decerr = 2'b11;

    // Memory window, the depth behind it may be smaller and then wraps
    localparam addr_t mem_base  = 32'h0000_0000;
    localparam addr_t mem_span  = 32'h0001_0000;

    localparam addr_t regs_base = 32'h1000_0000;
    localparam addr_t regs_span = 32'h0000_0010;    // Four 32-bit registers

endpackage

// ==== logic/axil_splitter.sv ====
/* One master to two AXI-Lite slaves, one transaction per direction at a time.
   Unmapped addresses are answered here with DECERR, and read data is then zero */
`timescale 1ns/1ns
module axil_splitter (
    input  logic            aclk,
    input  logic            aresetn,

    input  axil_pkg::addr_t s_axil_awaddr,
    input  logic [2:0]      s_axil_awprot,
    input  logic            s_axil_awvalid,
    output logic            s_axil_awready,
    input  axil_pkg::data_t s_axil_wdata,
    input  axil_pkg::strb_t s_axil_wstrb,
    input  logic            s_axil_wvalid,
    output logic            s_axil_wready,
    output axil_pkg::resp_t s_axil_bresp,
    output logic            s_axil_bvalid,
    input  logic            s_axil_bready,
    input  axil_pkg::addr_t s_axil_araddr,
    input  logic [2:0]      s_axil_arprot,
    input  logic            s_axil_arvalid,
    output logic            s_axil_arready,
    output axil_pkg::data_t s_axil_rdata,
    output axil_pkg::resp_t s_axil_rresp,
    output logic            s_axil_rvalid,
    input  logic            s_axil_rready,

    output axil_pkg::addr_t m_mem_awaddr,
    output logic [2:0]      m_mem_awprot,
    output logic            m_mem_awvalid,
    input  logic            m_mem_awready,
    output axil_pkg::data_t m_mem_wdata,
    output axil_pkg::strb_t m_mem_wstrb,
    output logic            m_mem_wvalid,
    input  logic            m_mem_wready,
    input  axil_pkg::resp_t m_mem_bresp,
    input  logic            m_mem_bvalid,
    output logic            m_mem_bready,
    output axil_pkg::addr_t m_mem_araddr,
    output logic [2:0]      m_mem_arprot,
    output logic            m_mem_arvalid,
    input  logic            m_mem_arready,
    input  axil_pkg::data_t m_mem_rdata,
    input  axil_pkg::resp_t m_mem_rresp,
    input  logic            m_mem_rvalid,
    output logic            m_mem_rready,

    output axil_pkg::addr_t m_reg_awaddr,
    output logic [2:0]      m_reg_awprot,
    output logic            m_reg_awvalid,
    input  logic            m_reg_awready,
    output axil_pkg::data_t m_reg_wdata,
    output axil_pkg::strb_t m_reg_wstrb,
    output logic            m_reg_wvalid,
    input  logic            m_reg_wready,
    input  axil_pkg::resp_t m_reg_bresp,
    input  logic            m_reg_bvalid,
    output logic            m_reg_bready,
    output axil_pkg::addr_t m_reg_araddr,
    output logic [2:0]      m_reg_arprot,
    output logic            m_reg_arvalid,
    input  logic            m_reg_arready,
    input  axil_pkg::data_t m_reg_rdata,
    input  axil_pkg::resp_t m_reg_rresp,
    input  logic            m_reg_rvalid,
    output logic            m_reg_rready
);
    import axil_pkg::*;

    typedef enum logic [1:0] {sel_idle, sel_mem, sel_regs, sel_err} sel_t;

    sel_t wr_sel;   // Owner of the pending write response
    sel_t rd_sel;
    sel_t aw_dec;
    sel_t ar_dec;
    logic wr_fire;
    logic rd_fire;

    // Unsigned wrap makes addresses below a base fall outside its window
    function automatic sel_t decode(input addr_t addr);
        if ((addr - mem_base) < mem_span) begin
            return sel_mem;
        end
        if ((addr - regs_base) < regs_span) begin
            return sel_regs;
        end
        return sel_err;
    endfunction

    assign aw_dec = decode(s_axil_awaddr);
    assign ar_dec = decode(s_axil_araddr);

    assign m_mem_awaddr = s_axil_awaddr - mem_base;
    assign m_reg_awaddr = s_axil_awaddr - regs_base;
    assign m_mem_araddr = s_axil_araddr - mem_base;
    assign m_reg_araddr = s_axil_araddr - regs_base;
    assign m_mem_awprot = s_axil_awprot;
    assign m_reg_awprot = s_axil_awprot;
    assign m_mem_arprot = s_axil_arprot;
    assign m_reg_arprot = s_axil_arprot;
    assign m_mem_wdata  = s_axil_wdata;
    assign m_reg_wdata  = s_axil_wdata;
    assign m_mem_wstrb  = s_axil_wstrb;
    assign m_reg_wstrb  = s_axil_wstrb;

    // The w channel follows the decode of the address it travels with
    assign m_mem_awvalid = wr_sel == sel_idle && aw_dec == sel_mem && s_axil_awvalid;
    assign m_reg_awvalid = wr_sel == sel_idle && aw_dec == sel_regs && s_axil_awvalid;
    assign m_mem_wvalid  = wr_sel == sel_idle && aw_dec == sel_mem && s_axil_wvalid;
    assign m_reg_wvalid  = wr_sel == sel_idle && aw_dec == sel_regs && s_axil_wvalid;

    assign s_axil_awready = wr_sel != sel_idle ? 1'b0 :
                            aw_dec == sel_mem  ? m_mem_awready :
                            aw_dec == sel_regs ? m_reg_awready :
                            s_axil_awvalid && s_axil_wvalid;
    assign s_axil_wready  = wr_sel != sel_idle ? 1'b0 :
                            aw_dec == sel_mem  ? m_mem_wready :
                            aw_dec == sel_regs ? m_reg_wready :
                            s_axil_awvalid && s_axil_wvalid;
    assign wr_fire = s_axil_awvalid && s_axil_awready;

    assign s_axil_bvalid = wr_sel == sel_mem  ? m_mem_bvalid :
                           wr_sel == sel_regs ? m_reg_bvalid : wr_sel == sel_err;
    assign s_axil_bresp  = wr_sel == sel_mem  ? m_mem_bresp :
                           wr_sel == sel_regs ? m_reg_bresp : resp_decerr;
    assign m_mem_bready  = wr_sel == sel_mem && s_axil_bready;
    assign m_reg_bready  = wr_sel == sel_regs && s_axil_bready;

    assign m_mem_arvalid = rd_sel == sel_idle && ar_dec == sel_mem && s_axil_arvalid;
    assign m_reg_arvalid = rd_sel == sel_idle && ar_dec == sel_regs && s_axil_arvalid;

    assign s_axil_arready = rd_sel != sel_idle ? 1'b0 :
                            ar_dec == sel_mem  ? m_mem_arready :
                            ar_dec == sel_regs ? m_reg_arready : 1'b1;
    assign rd_fire = s_axil_arvalid && s_axil_arready;

    assign s_axil_rvalid = rd_sel == sel_mem  ? m_mem_rvalid :
                           rd_sel == sel_regs ? m_reg_rvalid : rd_sel == sel_err;
    assign s_axil_rresp  = rd_sel == sel_mem  ? m_mem_rresp :
                           rd_sel == sel_regs ? m_reg_rresp : resp_decerr;
    assign s_axil_rdata  = rd_sel == sel_mem  ? m_mem_rdata :
                           rd_sel == sel_regs ? m_reg_rdata : '0;
    assign m_mem_rready  = rd_sel == sel_mem && s_axil_rready;
    assign m_reg_rready  = rd_sel == sel_regs && s_axil_rready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_sel <= sel_idle;
            rd_sel <= sel_idle;
        end else begin
            if (wr_fire) begin
                wr_sel <= aw_dec;
            end else if (s_axil_bvalid && s_axil_bready) begin
                wr_sel <= sel_idle;
            end
            if (rd_fire) begin
                rd_sel <= ar_dec;
            end else if (s_axil_rvalid && s_axil_rready) begin
                rd_sel <= sel_idle;
            end
        end
    end

    a_one_aw: assert property (@(posedge aclk) disable iff (!aresetn)
        !(m_mem_awvalid && m_reg_awvalid));

    a_one_ar: assert property (@(posedge aclk) disable iff (!aresetn)
        !(m_mem_arvalid && m_reg_arvalid));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, the output is searched for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_axil_mem_system -Mdir obj_dir -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed!" &&
echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }
